// File: hw/ctrl_pkg.sv
package ctrl_pkg;

        localparam int STEP_W = 4;

        // Opcode and funct fields
        localparam logic [5:0] OP_TYPE_R = 6'h00;
        localparam logic [5:0] OP_J      = 6'h02;
        localparam logic [5:0] OP_BEQ    = 6'h04;
        localparam logic [5:0] OP_BNE    = 6'h05;
        localparam logic [5:0] OP_LW     = 6'h23;
        localparam logic [5:0] OP_SW     = 6'h2b;

        localparam logic [5:0] FUNCT_ADD = 6'h20;
        localparam logic [5:0] FUNCT_SUB = 6'h22;
        localparam logic [5:0] FUNCT_AND = 6'h24;

        typedef enum logic [5:0] {
                ST_FETCH,
                ST_DECODE,
                ST_ALU_EXEC,
                ST_BRANCH,
                ST_JUMP,
                ST_MEM_ADDR,
                ST_LOAD,
                ST_STORE,
                ST_EXCEPTION
        } state_e;

        typedef enum logic [3:0] {
                CLS_ADD,
                CLS_SUB,
                CLS_AND,
                CLS_BEQ,
                CLS_BNE,
                CLS_J,
                CLS_LW,
                CLS_SW,
                CLS_INVALID
        } instr_e;

        typedef enum logic [2:0] {
                ALU_ADD = 3'b001,
                ALU_SUB = 3'b010,
                ALU_AND = 3'b011,
                ALU_CMP = 3'b111        // Compare that drives eq
        } alu_op_e;

        typedef enum logic [1:0] {PC_SRC_ALU_OUT, PC_SRC_OFFSET, PC_SRC_LOAD, PC_SRC_EPC} pc_src_e;
        typedef enum logic [1:0] {A_SRC_PC, A_SRC_A, A_SRC_B} src_a_e;
        typedef enum logic [1:0] {B_SRC_B, B_SRC_FOUR, B_SRC_IMMEDIATE, B_SRC_BRANCH_ADDR} src_b_e;

        typedef enum logic [2:0] {BANK_RT = 3'b000, BANK_RD = 3'b001} bank_reg_e;
        typedef enum logic [2:0] {BANK_ALU = 3'b000, BANK_LOAD = 3'b001} bank_data_e;

        // The last two memory address sources are exception vectors
        typedef enum logic [2:0] {PC_ADDR, ALU_ADDR, VEC_OP_INEX, VEC_OVERFLOW} iord_e;

        typedef struct packed {
                logic zero;
                logic overflow;
                logic eq;
        } alu_flags_t;

        typedef struct packed {
                pc_src_e    pc_src;
                src_a_e     alu_src_a;
                src_b_e     alu_src_b;
                alu_op_e    alu_op;
                iord_e      iord;
                bank_reg_e  bank_reg;
                bank_data_e bank_data;
        } ctrl_sel_t;

        typedef struct packed {
                logic wr;               // Memory write
                logic ir_write;
                logic pc_write;
                logic bank_write;
                logic epc_write;
                logic a_write;
                logic b_write;
                logic alu_out_write;
                logic mem_reg_write;
        } ctrl_wen_t;

endpackage

// File: hw/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
        input  logic [5:0]        op,
        input  logic [5:0]        funct,
        output ctrl_pkg::instr_e  cls
);

        always_comb begin
                case (op)
                        ctrl_pkg::OP_TYPE_R: begin
                                // R-type goes by funct
                                case (funct)
                                        ctrl_pkg::FUNCT_ADD: cls = ctrl_pkg::CLS_ADD;
                                        ctrl_pkg::FUNCT_SUB: cls = ctrl_pkg::CLS_SUB;
                                        ctrl_pkg::FUNCT_AND: cls = ctrl_pkg::CLS_AND;
                                        default:             cls = ctrl_pkg::CLS_INVALID;
                                endcase
                        end
                        ctrl_pkg::OP_BEQ: cls = ctrl_pkg::CLS_BEQ;
                        ctrl_pkg::OP_BNE: cls = ctrl_pkg::CLS_BNE;
                        ctrl_pkg::OP_J:   cls = ctrl_pkg::CLS_J;
                        ctrl_pkg::OP_LW:  cls = ctrl_pkg::CLS_LW;
                        ctrl_pkg::OP_SW:  cls = ctrl_pkg::CLS_SW;
                        default:          cls = ctrl_pkg::CLS_INVALID;     // Unknown opcode
                endcase
        end

endmodule

// File: hw/step_sequencer.sv
`timescale 1ns/10ps

module step_sequencer #(
        parameter int FETCH_WAIT = 3
) (
        input  logic                        clk,
        input  logic                        reset,
        input  ctrl_pkg::instr_e            cls,
        input  ctrl_pkg::alu_flags_t        flags,
        output ctrl_pkg::state_e            state,
        output logic [ctrl_pkg::STEP_W-1:0] step,
        output logic                        last_step,
        output ctrl_pkg::iord_e             exc_cause
);

        typedef logic [ctrl_pkg::STEP_W-1:0] step_t;

        ctrl_pkg::state_e next_state;
        step_t            last_idx;

        // Index of the final step in each state
        always_comb begin
                case (state)
                        ctrl_pkg::ST_FETCH,
                        ctrl_pkg::ST_MEM_ADDR,
                        ctrl_pkg::ST_EXCEPTION: last_idx = step_t'(FETCH_WAIT);
                        ctrl_pkg::ST_DECODE,
                        ctrl_pkg::ST_ALU_EXEC,
                        ctrl_pkg::ST_BRANCH:    last_idx = step_t'(1);
                        default:                last_idx = '0;
                endcase
        end

        assign last_step = (step == last_idx);

        always_comb begin
                next_state = state;
                if (last_step) begin
                        case (state)
                                ctrl_pkg::ST_FETCH: next_state = ctrl_pkg::ST_DECODE;
                                ctrl_pkg::ST_DECODE: begin
                                        case (cls)
                                                ctrl_pkg::CLS_ADD,
                                                ctrl_pkg::CLS_SUB,
                                                ctrl_pkg::CLS_AND: next_state = ctrl_pkg::ST_ALU_EXEC;
                                                ctrl_pkg::CLS_BEQ,
                                                ctrl_pkg::CLS_BNE: next_state = ctrl_pkg::ST_BRANCH;
                                                ctrl_pkg::CLS_J:   next_state = ctrl_pkg::ST_JUMP;
                                                ctrl_pkg::CLS_LW,
                                                ctrl_pkg::CLS_SW:  next_state = ctrl_pkg::ST_MEM_ADDR;
                                                default:           next_state = ctrl_pkg::ST_EXCEPTION;
                                        endcase
                                end
                                ctrl_pkg::ST_ALU_EXEC: begin
                                        next_state = flags.overflow ? ctrl_pkg::ST_EXCEPTION
                                                                    : ctrl_pkg::ST_FETCH;
                                end
                                ctrl_pkg::ST_MEM_ADDR: begin
                                        next_state = (cls == ctrl_pkg::CLS_SW) ? ctrl_pkg::ST_STORE
                                                                               : ctrl_pkg::ST_LOAD;
                                end
                                default: next_state = ctrl_pkg::ST_FETCH;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        state     <= ctrl_pkg::ST_FETCH;
                        step      <= '0;
                        exc_cause <= ctrl_pkg::PC_ADDR;
                end else begin
                        state <= next_state;
                        step  <= last_step ? '0 : step + 1'b1;
                        // Only decode and ALU execution can raise an exception
                        if (next_state == ctrl_pkg::ST_EXCEPTION &&
                            state != ctrl_pkg::ST_EXCEPTION) begin
                                exc_cause <= (state == ctrl_pkg::ST_ALU_EXEC) ?
                                             ctrl_pkg::VEC_OVERFLOW : ctrl_pkg::VEC_OP_INEX;
                        end
                end
        end

        a_step_bound: assert property (@(posedge clk) disable iff (reset)
                step <= FETCH_WAIT)
                else $error("step counter past FETCH_WAIT");

endmodule

// File: hw/control_word_gen.sv
`timescale 1ns/10ps

module control_word_gen (
        input  ctrl_pkg::state_e            state,
        input  logic [ctrl_pkg::STEP_W-1:0] step,
        input  logic                        last_step,
        input  ctrl_pkg::iord_e             exc_cause,
        input  ctrl_pkg::instr_e            cls,
        input  ctrl_pkg::alu_flags_t        flags,
        output ctrl_pkg::ctrl_sel_t         sel,
        output ctrl_pkg::ctrl_wen_t         wen
);

        logic first_step;

        assign first_step = (step == '0);

        always_comb begin
                // Fetch values give PC + 4 on the PC address
                sel.pc_src    = ctrl_pkg::PC_SRC_ALU_OUT;
                sel.alu_src_a = ctrl_pkg::A_SRC_PC;
                sel.alu_src_b = ctrl_pkg::B_SRC_FOUR;
                sel.alu_op    = ctrl_pkg::ALU_ADD;
                sel.iord      = ctrl_pkg::PC_ADDR;
                sel.bank_reg  = ctrl_pkg::BANK_RT;
                sel.bank_data = ctrl_pkg::BANK_ALU;
                wen           = '0;

                case (state)
                        ctrl_pkg::ST_FETCH: begin
                                wen.alu_out_write = 1'b1;
                                wen.ir_write      = last_step;
                                wen.pc_write      = last_step;
                        end
                        ctrl_pkg::ST_DECODE: begin
                                if (first_step) begin
                                        // Branch target ahead of time
                                        sel.alu_src_b     = ctrl_pkg::B_SRC_BRANCH_ADDR;
                                        wen.a_write       = 1'b1;
                                        wen.b_write       = 1'b1;
                                        wen.alu_out_write = 1'b1;
                                end
                        end
                        ctrl_pkg::ST_ALU_EXEC: begin
                                sel.alu_src_a = ctrl_pkg::A_SRC_A;
                                sel.alu_src_b = ctrl_pkg::B_SRC_B;
                                case (cls)
                                        ctrl_pkg::CLS_SUB: sel.alu_op = ctrl_pkg::ALU_SUB;
                                        ctrl_pkg::CLS_AND: sel.alu_op = ctrl_pkg::ALU_AND;
                                        default:           sel.alu_op = ctrl_pkg::ALU_ADD;
                                endcase
                                sel.bank_reg      = ctrl_pkg::BANK_RD;
                                wen.alu_out_write = first_step;
                                wen.bank_write    = last_step && !flags.overflow;
                        end
                        ctrl_pkg::ST_BRANCH: begin
                                sel.alu_src_a = ctrl_pkg::A_SRC_A;
                                sel.alu_src_b = ctrl_pkg::B_SRC_B;
                                sel.alu_op    = ctrl_pkg::ALU_CMP;
                                if (last_step) begin
                                        // ALU_OUT still holds the target from decode
                                        wen.pc_write = (cls == ctrl_pkg::CLS_BEQ) ? flags.eq
                                                                                  : !flags.eq;
                                end
                        end
                        ctrl_pkg::ST_JUMP: begin
                                sel.pc_src   = ctrl_pkg::PC_SRC_OFFSET;
                                wen.pc_write = 1'b1;
                        end
                        ctrl_pkg::ST_MEM_ADDR: begin
                                sel.alu_src_a     = ctrl_pkg::A_SRC_A;
                                sel.alu_src_b     = ctrl_pkg::B_SRC_IMMEDIATE;
                                sel.iord          = ctrl_pkg::ALU_ADDR;
                                wen.alu_out_write = first_step;
                                wen.mem_reg_write = last_step;
                        end
                        ctrl_pkg::ST_LOAD: begin
                                sel.bank_data  = ctrl_pkg::BANK_LOAD;
                                wen.bank_write = 1'b1;
                        end
                        ctrl_pkg::ST_STORE: begin
                                sel.iord = ctrl_pkg::ALU_ADDR;
                                wen.wr   = 1'b1;
                        end
                        ctrl_pkg::ST_EXCEPTION: begin
                                sel.alu_op        = ctrl_pkg::ALU_SUB;        // EPC = PC - 4
                                sel.iord          = exc_cause;
                                sel.pc_src        = ctrl_pkg::PC_SRC_LOAD;
                                wen.epc_write     = !last_step;
                                wen.mem_reg_write = !last_step;
                                wen.pc_write      = last_step;     // Jump to the vector
                        end
                        default: ;
                endcase

                a_wr_vs_bank: assert (!(wen.wr && wen.bank_write))
                        else $error("memory write and bank write in the same cycle");
        end

endmodule

// File: hw/control_unit.sv
`timescale 1ns/10ps

module control_unit #(
        parameter int FETCH_WAIT = 3
) (
        input  logic                 clk,
        input  logic                 reset,
        input  logic [5:0]           op,
        input  logic [5:0]           funct,
        input  ctrl_pkg::alu_flags_t flags,
        output ctrl_pkg::ctrl_sel_t  sel,
        output ctrl_pkg::ctrl_wen_t  wen
);

        ctrl_pkg::instr_e            cls;
        ctrl_pkg::state_e            state;
        logic [ctrl_pkg::STEP_W-1:0] step;
        logic                        last_step;
        ctrl_pkg::iord_e             exc_cause;

        instr_decoder i_instr_decoder (
                .op    (op),
                .funct (funct),
                .cls   (cls)
        );

        step_sequencer #(
                .FETCH_WAIT (FETCH_WAIT)
        ) i_step_sequencer (
                .clk       (clk),
                .reset     (reset),
                .cls       (cls),
                .flags     (flags),
                .state     (state),
                .step      (step),
                .last_step (last_step),
                .exc_cause (exc_cause)
        );

        control_word_gen i_control_word_gen (
                .state     (state),
                .step      (step),
                .last_step (last_step),
                .exc_cause (exc_cause),
                .cls       (cls),
                .flags     (flags),
                .sel       (sel),
                .wen       (wen)
        );

endmodule

// File: verif/tb_control_unit.sv
`timescale 1ns/10ps

module tb_control_unit;

        localparam int FETCH_WAIT   = 3;
        localparam int CLK_PERIOD   = 20;
        localparam int RESET_CYCLES = 16;
        localparam int NUM_CASES    = 14;
        localparam int NUM_COLS     = 11;

        logic                 clk;
        logic                 reset;
        logic [5:0]           op;
        logic [5:0]           funct;
        ctrl_pkg::alu_flags_t flags;
        ctrl_pkg::ctrl_sel_t  sel;
        ctrl_pkg::ctrl_wen_t  wen;

        logic [7:0]  cases_mem [0:NUM_CASES*NUM_COLS-1];
        logic [31:0] lfsr;

        control_unit #(
                .FETCH_WAIT (FETCH_WAIT)
        ) i_control_unit (
                .clk   (clk),
                .reset (reset),
                .op    (op),
                .funct (funct),
                .flags (flags),
                .sel   (sel),
                .wen   (wen)
        );

        always #(CLK_PERIOD / 2) clk = ~clk;

        // Taps 32, 22, 2, 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        task automatic random_bit(output logic b);
                lfsr = lfsr_next(lfsr);
                b    = lfsr[0];
        endtask

        task automatic abort_run(input string why);
                $display("sim failed");
                $fatal(1, "%s", why);
        endtask

        task automatic check_count(input string what, input int got, input int exp);
                if (got != exp) begin
                        $display("[ERROR] %0t ns: %s got %0d expected %0d", $time, what, got, exp);
                        abort_run("wrong cycle count");
                end
        endtask

        task automatic check_sel(input string what, input ctrl_pkg::ctrl_sel_t got,
                                 input ctrl_pkg::ctrl_sel_t exp);
                if (got != exp) begin
                        $display("[ERROR] %0t ns: %s got %b expected %b", $time, what, got, exp);
                        abort_run("wrong select value");
                end
        endtask

        task automatic check_wen(input string what, input ctrl_pkg::ctrl_wen_t got,
                                 input ctrl_pkg::ctrl_wen_t exp);
                if (got != exp) begin
                        $display("[ERROR] %0t ns: %s got %b expected %b", $time, what, got, exp);
                        abort_run("wrong write enable value");
                end
        endtask

        // Column value 2 means a fresh LFSR bit every cycle
        task automatic drive_flags(input logic [7:0] eq_col, input logic [7:0] ovf_col);
                logic b;
                random_bit(b);
                flags.zero = b;         // Not used by the unit
                flags.eq = eq_col[0];
                if (eq_col == 8'h2) begin
                        random_bit(b);
                        flags.eq = b;
                end
                flags.overflow = ovf_col[0];
                if (ovf_col == 8'h2) begin
                        random_bit(b);
                        flags.overflow = b;
                end
        endtask

        // Runs from one ir_write cycle to the next
        task automatic run_case(input int idx);
                logic [7:0]          c [NUM_COLS];
                ctrl_pkg::ctrl_wen_t seen;
                ctrl_pkg::ctrl_wen_t exp_wen;
                ctrl_pkg::ctrl_sel_t got_sel;
                ctrl_pkg::ctrl_sel_t exp_sel;
                logic                done;
                int                  n;
                for (int k = 0; k < NUM_COLS; k++)
                        c[k] = cases_mem[idx * NUM_COLS + k];
                op    = c[0][5:0];
                funct = c[1][5:0];
                drive_flags(c[2], c[3]);
                seen = '0;
                n    = 0;
                do begin
                        @(negedge clk);
                        n++;
                        done = wen.ir_write;
                        if (!done) begin
                                seen = ctrl_pkg::ctrl_wen_t'(seen | wen);
                                got_sel = '0;
                                exp_sel = '0;
                                if (wen.a_write) begin
                                        // Branch target is PC plus the branch offset
                                        got_sel.alu_src_a = sel.alu_src_a;
                                        got_sel.alu_src_b = sel.alu_src_b;
                                        got_sel.alu_op    = sel.alu_op;
                                        exp_sel.alu_src_a = ctrl_pkg::A_SRC_PC;
                                        exp_sel.alu_src_b = ctrl_pkg::B_SRC_BRANCH_ADDR;
                                        exp_sel.alu_op    = ctrl_pkg::ALU_ADD;
                                end
                                if (wen.bank_write) begin
                                        got_sel.bank_reg  = sel.bank_reg;
                                        got_sel.bank_data = sel.bank_data;
                                        exp_sel.bank_reg  = ctrl_pkg::bank_reg_e'(c[5][2:0]);
                                        exp_sel.bank_data = ctrl_pkg::bank_data_e'(c[6][2:0]);
                                        if (c[10] != 8'h0) begin
                                                got_sel.alu_op = sel.alu_op;
                                                exp_sel.alu_op = ctrl_pkg::alu_op_e'(c[10][2:0]);
                                                got_sel.alu_src_a = sel.alu_src_a;
                                                got_sel.alu_src_b = sel.alu_src_b;
                                                exp_sel.alu_src_a = ctrl_pkg::A_SRC_A;
                                                exp_sel.alu_src_b = ctrl_pkg::B_SRC_B;
                                        end
                                end
                                if (wen.pc_write) begin
                                        got_sel.pc_src = sel.pc_src;
                                        exp_sel.pc_src = ctrl_pkg::pc_src_e'(c[7][1:0]);
                                end
                                if (wen.epc_write) begin
                                        got_sel.iord = sel.iord;    // Exception vector
                                        exp_sel.iord = ctrl_pkg::iord_e'(c[9][2:0]);
                                end
                                if (wen.wr) begin
                                        got_sel.iord = sel.iord;
                                        exp_sel.iord = ctrl_pkg::ALU_ADDR;
                                end
                                check_sel($sformatf("case %0d sel", idx), got_sel, exp_sel);
                        end
                        drive_flags(c[2], c[3]);
                end while (!done);
                check_count($sformatf("case %0d cycles", idx), n, int'(c[4]));

                exp_wen               = '0;
                exp_wen.a_write       = 1'b1;
                exp_wen.b_write       = 1'b1;
                exp_wen.alu_out_write = 1'b1;
                exp_wen.bank_write    = (c[5] != 8'hf);
                exp_wen.pc_write      = (c[7] != 8'hf);
                exp_wen.wr            = c[8][0];
                exp_wen.epc_write     = (c[9] != 8'h0);
                // Every memory access and vector load fills the memory data register
                exp_wen.mem_reg_write = c[8][0] || (c[6] == 8'h1) || (c[9] != 8'h0);
                check_wen($sformatf("case %0d wen", idx), seen, exp_wen);
        endtask

        initial begin
                ctrl_pkg::ctrl_wen_t exp_wen;
                int                  n;
                clk   = 1'b0;
                reset = 1'b1;
                op    = '0;
                funct = '0;
                flags = '0;
                lfsr  = 32'h1851_bb96;
                $readmemh("verif/control_cases.txt", cases_mem);
                if ($isunknown(cases_mem[NUM_CASES*NUM_COLS-1]))
                        abort_run("case file is missing or shorter than expected");

                repeat (RESET_CYCLES) @(negedge clk);
                reset = 1'b0;
                exp_wen               = '0;
                exp_wen.alu_out_write = 1'b1;
                check_wen("wen after reset", wen, exp_wen);
                n = 1;
                while (!wen.ir_write) begin
                        @(negedge clk);
                        n++;
                end
                check_count("cycles to first ir_write", n, FETCH_WAIT + 1);

                for (int i = 0; i < NUM_CASES; i++)
                        run_case(i);
                $display("sim passed");
                $finish;
        end

        initial begin
                #((RESET_CYCLES + FETCH_WAIT + 1 + NUM_CASES * 20) * CLK_PERIOD);
                abort_run("watchdog timeout, the control unit stopped issuing ir_write");
        end

endmodule

// File: verif/control_cases.txt
// op funct eq ovf cycles bank_reg bank_data pc_src wr vector alu_op
// eq/ovf 2 = random, bank_reg/pc_src f = no write, vector 0 = none, alu_op 0 = not checked
00 20 2 0 08 1 0 f 0 0 1
00 22 2 0 08 1 0 f 0 0 2
00 24 2 0 08 1 0 f 0 0 3
00 20 2 1 0c f 0 2 0 3 0
00 22 2 1 0c f 0 2 0 3 0
04 00 1 2 08 f 0 0 0 0 0
04 00 0 2 08 f 0 f 0 0 0
05 00 1 2 08 f 0 f 0 0 0
05 00 0 2 08 f 0 0 0 0 0
02 00 2 2 07 f 0 1 0 0 0
23 00 2 2 0b 0 1 f 0 0 0
2b 00 2 2 0b f 0 f 1 0 0
3f 00 2 2 0a f 0 2 0 2 0
00 25 2 2 0a f 0 2 0 2 0

// File: compile.f
hw/ctrl_pkg.sv
hw/instr_decoder.sv
hw/step_sequencer.sv
hw/control_word_gen.sv
hw/control_unit.sv
verif/tb_control_unit.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_control_unit
FILELIST := compile.f
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
